// ==== bootrom.hex ====
// One 32-bit boot word per line, word index 0 at the top
00000013
00100093
00200113
00300193
00400213
00500293
00600313
00700393
deadbeef
cafef00d
12345678
9abcdef0
0f1e2d3c
4b5a6978
a5a5c3c3
0000006f

// ==== sim.f ====
hdl/mem_sys_pkg.sv
hdl/data_port_arbiter.sv
hdl/unified_ram.sv
hdl/mmio_regs.sv
hdl/mem_subsys_top.sv
test/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_mem_subsys -f sim.f -o sim_tb

sim_out=$(./obj_dir/sim_tb)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Test OK"; then
	exit 0
fi
exit 1

// ==== test/tb_mem_subsys.sv ====
`timescale 1ns/1ns

module tb_mem_subsys;
	import mem_sys_pkg::*;

	localparam int CYCLE_LIMIT = 400;

	logic          clkrst_core_clk;
	logic          rst_n;
	logic          port0_valid;
	data_req_t     port0_req;
	data_rsp_t     port0_rsp;
	logic          port1_valid;
	data_req_t     port1_req;
	data_rsp_t     port1_rsp;
	logic          fetch_valid;
	fetch_addr_t   fetch_addr;
	fetch_packet_t fetch_packet;
	logic          fetch_done;
	word_t         gpio_in;
	word_t         gpio_out;

	word_t  mem_model [16];	// Boot words plus every write issued
	word_t  gpio_model;
	integer seed = 32'hb57b_10d0;
	int     error_count = 0;
	int     pass_count = 0;
	int     fail_count = 0;
	int     cycle_count = 0;

	mem_subsys_top uut (
		.clkrst_core_clk (clkrst_core_clk),
		.rst_n           (rst_n),
		.port0_valid     (port0_valid),
		.port0_req       (port0_req),
		.port0_rsp       (port0_rsp),
		.port1_valid     (port1_valid),
		.port1_req       (port1_req),
		.port1_rsp       (port1_rsp),
		.fetch_valid     (fetch_valid),
		.fetch_addr      (fetch_addr),
		.fetch_packet    (fetch_packet),
		.fetch_done      (fetch_done),
		.gpio_in         (gpio_in),
		.gpio_out        (gpio_out)
	);

	initial begin
		clkrst_core_clk = 1'b0;
		forever #50 clkrst_core_clk = ~clkrst_core_clk;
	end

	always @(posedge clkrst_core_clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
		input byte_en_t be);
		word_t result;
		result = old_word;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				result[b*8 +: 8] = new_word[b*8 +: 8];
		end
		return result;
	endfunction

	function automatic word_addr_t ram_address(input int index);
		return 30'(index);
	endfunction

	function automatic word_addr_t mmio_address(input int offset);
		return {1'b1, 29'(offset)};
	endfunction

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			$display("%-16s passed", name);
			pass_count++;
		end else begin
			$display("%-16s failed with %0d errors", name, error_count - errors_before);
			fail_count++;
		end
	endtask

	// Starts just after a falling edge and returns on the falling edge that saw done
	task automatic data_access(input int port, input word_addr_t addr, input byte_en_t be,
		input word_t wdata, output word_t rdata);
		data_req_t req;
		int        waited;
		logic      got_done;
		req.addr  = addr;
		req.write = be;
		req.wdata = wdata;
		if (port == 0) begin
			port0_req   = req;
			port0_valid = 1'b1;
		end else begin
			port1_req   = req;
			port1_valid = 1'b1;
		end
		waited   = 0;
		got_done = 1'b0;
		while (!got_done && waited < 4) begin
			@(negedge clkrst_core_clk);
			waited++;
			got_done = (port == 0) ? port0_rsp.done : port1_rsp.done;
		end
		rdata       = (port == 0) ? port0_rsp.rdata : port1_rsp.rdata;
		port0_valid = 1'b0;
		port1_valid = 1'b0;
		if (!got_done) begin
			$display("Port %0d got no done strobe within 4 cycles of its request", port);
			error_count++;
		end
	endtask

	task automatic fetch_and_compare(input fetch_addr_t addr, input int first_word);
		fetch_addr  = addr;
		fetch_valid = 1'b1;
		@(negedge clkrst_core_clk);
		check_value("fetch_done", 32'd1, 32'(fetch_done));
		for (int w = 0; w < 4; w++) begin
			check_value($sformatf("fetch_packet[%0d]", w), mem_model[first_word + w],
				fetch_packet[w*32 +: 32]);
		end
		fetch_valid = 1'b0;
		@(negedge clkrst_core_clk);
		check_value("fetch_done", 32'd0, 32'(fetch_done));	// Single cycle only
	endtask

	task automatic test_reset_state();
		int errors_before;
		errors_before = error_count;
		// Requests held through reset must not reach done or gpio_out
		port0_req   = '{addr: mmio_address(MMIO_OUT_OFFSET), write: 4'hf,
			wdata: 32'hffff_ffff};
		port0_valid = 1'b1;
		port1_valid = 1'b1;
		fetch_valid = 1'b1;
		repeat (5) begin
			@(negedge clkrst_core_clk);
			check_value("port0_rsp.done", 32'd0, 32'(port0_rsp.done));
			check_value("port1_rsp.done", 32'd0, 32'(port1_rsp.done));
			check_value("fetch_done", 32'd0, 32'(fetch_done));
			check_value("gpio_out", 32'd0, gpio_out);
		end
		rst_n       = 1'b1;
		port0_valid = 1'b0;
		port1_valid = 1'b0;
		fetch_valid = 1'b0;
		@(negedge clkrst_core_clk);
		check_value("port0_rsp.done", 32'd0, 32'(port0_rsp.done));
		check_value("port1_rsp.done", 32'd0, 32'(port1_rsp.done));
		check_value("fetch_done", 32'd0, 32'(fetch_done));
		check_value("gpio_out", 32'd0, gpio_out);
		finish_test("reset_state", errors_before);
	endtask

	task automatic test_boot_fetch();
		int    errors_before;
		word_t wdata;
		word_t rdata;
		errors_before = error_count;
		for (int a = 0; a < 4; a++)
			fetch_and_compare(28'(a), a * 4);
		wdata = $random(seed);
		data_access(0, ram_address(5), 4'hf, wdata, rdata);
		mem_model[5] = wdata;
		fetch_and_compare(28'h0000001, 4);
		fetch_and_compare(28'h0001001, 4);	// Wraps back onto packet 1
		finish_test("boot_fetch", errors_before);
	endtask

	task automatic test_byte_masked();
		int    errors_before;
		word_t wdata;
		word_t rdata;
		errors_before = error_count;
		wdata = $random(seed);
		data_access(0, ram_address(8), 4'hf, wdata, rdata);
		mem_model[8] = wdata;
		wdata = $random(seed);
		data_access(0, ram_address(8), 4'b0101, wdata, rdata);
		mem_model[8] = merge_bytes(mem_model[8], wdata, 4'b0101);
		data_access(0, ram_address(8), 4'h0, 32'd0, rdata);
		check_value("port0 rdata word 8", mem_model[8], rdata);
		data_access(0, ram_address(2), 4'h0, 32'd0, rdata);
		check_value("port0 rdata word 2", mem_model[2], rdata);
		data_access(0, ram_address(9), 4'h0, 32'd0, rdata);
		check_value("port0 rdata word 9", mem_model[9], rdata);
		data_access(0, ram_address(15), 4'h0, 32'd0, rdata);
		check_value("port0 rdata word 15", mem_model[15], rdata);
		finish_test("byte_masked", errors_before);
	endtask

	task automatic test_arbitration();
		int errors_before;
		errors_before = error_count;
		port0_req   = '{addr: ram_address(3), write: 4'h0, wdata: 32'd0};
		port1_req   = '{addr: ram_address(12), write: 4'h0, wdata: 32'd0};
		port0_valid = 1'b1;
		port1_valid = 1'b1;
		@(negedge clkrst_core_clk);
		check_value("port0_rsp.done", 32'd1, 32'(port0_rsp.done));
		check_value("port1_rsp.done", 32'd0, 32'(port1_rsp.done));
		check_value("port0_rsp.rdata", mem_model[3], port0_rsp.rdata);
		port0_valid = 1'b0;
		@(negedge clkrst_core_clk);
		check_value("port0_rsp.done", 32'd0, 32'(port0_rsp.done));
		check_value("port1_rsp.done", 32'd1, 32'(port1_rsp.done));
		check_value("port1_rsp.rdata", mem_model[12], port1_rsp.rdata);
		port1_valid = 1'b0;
		@(negedge clkrst_core_clk);
		check_value("port1_rsp.done", 32'd0, 32'(port1_rsp.done));
		finish_test("arbitration", errors_before);
	endtask

	task automatic test_mmio_region();
		int    errors_before;
		word_t wdata;
		word_t rdata;
		errors_before = error_count;
		wdata = $random(seed);
		data_access(0, mmio_address(MMIO_OUT_OFFSET), 4'hf, wdata, rdata);
		gpio_model = wdata;
		check_value("gpio_out", gpio_model, gpio_out);
		wdata = $random(seed);
		data_access(0, mmio_address(MMIO_OUT_OFFSET), 4'b1100, wdata, rdata);
		gpio_model = merge_bytes(gpio_model, wdata, 4'b1100);
		check_value("gpio_out", gpio_model, gpio_out);
		data_access(0, ram_address(0), 4'h0, 32'd0, rdata);
		check_value("port0 rdata word 0", mem_model[0], rdata);	// RAM untouched
		data_access(0, mmio_address(MMIO_OUT_OFFSET), 4'h0, 32'd0, rdata);
		check_value("port0 rdata gpio_out", gpio_model, rdata);
		gpio_in = $random(seed);
		repeat (2) @(negedge clkrst_core_clk);	// Let the sampler settle
		data_access(0, mmio_address(MMIO_IN_OFFSET), 4'h0, 32'd0, rdata);
		check_value("port0 rdata gpio_in", gpio_in, rdata);
		data_access(0, mmio_address(7), 4'h0, 32'd0, rdata);
		check_value("port0 rdata unused offset", 32'd0, rdata);
		finish_test("mmio_region", errors_before);
	endtask

	initial begin
		rst_n       = 1'b0;
		port0_valid = 1'b0;
		port0_req   = '0;
		port1_valid = 1'b0;
		port1_req   = '0;
		fetch_valid = 1'b0;
		fetch_addr  = '0;
		gpio_in     = '0;
		gpio_model  = '0;
		$readmemh(BOOTROM_FILE, mem_model);

		test_reset_state();
		test_boot_fetch();
		test_byte_masked();
		test_arbitration();
		test_mmio_region();

		$display("Tests passed: %0d, failed: %0d, check errors: %0d",
			pass_count, fail_count, error_count);
		if (fail_count == 0 && error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/1ns

module mem_subsys_top (
	input  logic                       clkrst_core_clk,
	input  logic                       rst_n,

	// Data ports from the core
	input  logic                       port0_valid,
	input  mem_sys_pkg::data_req_t     port0_req,
	output mem_sys_pkg::data_rsp_t     port0_rsp,
	input  logic                       port1_valid,
	input  mem_sys_pkg::data_req_t     port1_req,
	output mem_sys_pkg::data_rsp_t     port1_rsp,

	// Instruction fetch, already physical
	input  logic                       fetch_valid,
	input  mem_sys_pkg::fetch_addr_t   fetch_addr,
	output mem_sys_pkg::fetch_packet_t fetch_packet,
	output logic                       fetch_done,

	// GPIO pins
	input  mem_sys_pkg::word_t         gpio_in,
	output mem_sys_pkg::word_t         gpio_out
);
	import mem_sys_pkg::*;

	logic      mem_en;
	logic      mem_mmio_sel;
	data_req_t mem_req;
	word_t     ram_rdata;
	word_t     mmio_rdata;

	data_port_arbiter arbiter (
		.clkrst_core_clk (clkrst_core_clk),
		.rst_n           (rst_n),
		.port0_valid     (port0_valid),
		.port0_req       (port0_req),
		.port0_rsp       (port0_rsp),
		.port1_valid     (port1_valid),
		.port1_req       (port1_req),
		.port1_rsp       (port1_rsp),
		.mem_en          (mem_en),
		.mem_req         (mem_req),
		.mem_mmio_sel    (mem_mmio_sel),
		.ram_rdata       (ram_rdata),
		.mmio_rdata      (mmio_rdata)
	);

	unified_ram ram (
		.clkrst_core_clk (clkrst_core_clk),
		.rst_n           (rst_n),
		.mem_en          (mem_en),
		.mem_mmio_sel    (mem_mmio_sel),
		.mem_req         (mem_req),
		.ram_rdata       (ram_rdata),
		.fetch_valid     (fetch_valid),
		.fetch_addr      (fetch_addr),
		.fetch_packet    (fetch_packet),
		.fetch_done      (fetch_done)
	);

	mmio_regs mmio (
		.clkrst_core_clk (clkrst_core_clk),
		.rst_n           (rst_n),
		.mem_en          (mem_en),
		.mem_mmio_sel    (mem_mmio_sel),
		.mem_req         (mem_req),
		.mmio_rdata      (mmio_rdata),
		.gpio_in         (gpio_in),
		.gpio_out        (gpio_out)
	);

endmodule

// ==== hdl/mmio_regs.sv ====
`timescale 1ns/1ns

module mmio_regs (
	input  logic                   clkrst_core_clk,
	input  logic                   rst_n,

	// Shared memory port
	input  logic                   mem_en,
	input  logic                   mem_mmio_sel,
	input  mem_sys_pkg::data_req_t mem_req,
	output mem_sys_pkg::word_t     mmio_rdata,

	// Pins
	input  mem_sys_pkg::word_t     gpio_in,
	output mem_sys_pkg::word_t     gpio_out
);
	import mem_sys_pkg::*;

	logic         access;
	mmio_offset_t reg_offset;
	logic         out_hit;
	logic         in_hit;
	word_t        out_q;
	word_t        in_q;
	word_t        read_mux;

	assign access     = mem_en & mem_mmio_sel;
	assign reg_offset = mem_req.addr[MMIO_SEL_BIT-1:0];
	assign out_hit    = reg_offset == MMIO_SEL_BIT'(MMIO_OUT_OFFSET);
	assign in_hit     = reg_offset == MMIO_SEL_BIT'(MMIO_IN_OFFSET);

	// Output register, byte-masked
	always_ff @(posedge clkrst_core_clk) begin
		if (!rst_n) begin
			out_q <= '0;
		end else if (access && out_hit) begin
			for (int b = 0; b < 4; b++) begin
				if (mem_req.write[b]) begin
					out_q[b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
				end
			end
		end
	end

	// Input pins sampled every cycle
	always_ff @(posedge clkrst_core_clk) begin
		in_q <= gpio_in;
	end

	// Unused offsets read as zero
	always_comb begin
		if (out_hit)
			read_mux = out_q;	// Old value on a same-cycle write
		else if (in_hit)
			read_mux = in_q;
		else
			read_mux = '0;
	end

	always_ff @(posedge clkrst_core_clk) begin
		if (access) begin
			mmio_rdata <= read_mux;
		end
	end

	assign gpio_out = out_q;

endmodule

// ==== hdl/unified_ram.sv ====
`timescale 1ns/1ns

module unified_ram (
	input  logic                       clkrst_core_clk,
	input  logic                       rst_n,

	// Data port from the arbiter
	input  logic                       mem_en,
	input  logic                       mem_mmio_sel,
	input  mem_sys_pkg::data_req_t     mem_req,
	output mem_sys_pkg::word_t         ram_rdata,

	// Instruction fetch port
	input  logic                       fetch_valid,
	input  mem_sys_pkg::fetch_addr_t   fetch_addr,
	output mem_sys_pkg::fetch_packet_t fetch_packet,
	output logic                       fetch_done
);
	import mem_sys_pkg::*;

	word_t      mem [RAM_WORDS];
	ram_index_t data_index;
	logic       data_access;
	logic [FETCH_INDEX_BITS-1:0] fetch_index;

	// Boot image preload, contents are never reset
	initial begin
		$readmemh(BOOTROM_FILE, mem);
	end

	assign data_access = mem_en & ~mem_mmio_sel;
	assign data_index  = mem_req.addr[RAM_ADDR_BITS-1:0];
	assign fetch_index = fetch_addr[FETCH_INDEX_BITS-1:0];	// Wraps over 64 KB

	// Data port, byte-masked write with read of old contents
	always_ff @(posedge clkrst_core_clk) begin
		if (data_access) begin
			for (int b = 0; b < 4; b++) begin
				if (mem_req.write[b]) begin
					mem[data_index][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
				end
			end
			ram_rdata <= mem[data_index];
		end
	end

	// Fetch port reads four consecutive words
	always_ff @(posedge clkrst_core_clk) begin
		if (fetch_valid) begin
			for (int w = 0; w < FETCH_WORDS; w++) begin
				fetch_packet[w*32 +: 32] <= mem[{fetch_index, 2'(w)}];
			end
		end
	end

	// Packet is ready exactly one cycle after the strobe
	always_ff @(posedge clkrst_core_clk) begin
		if (!rst_n) begin
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= fetch_valid;
		end
	end

endmodule

// ==== hdl/data_port_arbiter.sv ====
`timescale 1ns/1ns

module data_port_arbiter (
	input  logic                   clkrst_core_clk,
	input  logic                   rst_n,

	// Core data ports, port 0 has priority
	input  logic                   port0_valid,
	input  mem_sys_pkg::data_req_t port0_req,
	output mem_sys_pkg::data_rsp_t port0_rsp,
	input  logic                   port1_valid,
	input  mem_sys_pkg::data_req_t port1_req,
	output mem_sys_pkg::data_rsp_t port1_rsp,

	// Shared memory port
	output logic                   mem_en,
	output mem_sys_pkg::data_req_t mem_req,
	output logic                   mem_mmio_sel,
	input  mem_sys_pkg::word_t     ram_rdata,
	input  mem_sys_pkg::word_t     mmio_rdata
);
	import mem_sys_pkg::*;

	logic  grant0;
	logic  grant1;
	logic  done0_q;
	logic  done1_q;
	logic  mmio_sel_q;	// Region of the access being answered
	word_t rsp_rdata;

	// Port 0 always wins, port 1 only gets idle cycles
	assign grant0 = port0_valid;
	assign grant1 = port1_valid & ~port0_valid;

	assign mem_en       = grant0 | grant1;
	assign mem_req      = grant0 ? port0_req : port1_req;
	assign mem_mmio_sel = mem_req.addr[MMIO_SEL_BIT];

	// Done strobes one cycle after service
	always_ff @(posedge clkrst_core_clk) begin
		if (!rst_n) begin
			done0_q <= 1'b0;
			done1_q <= 1'b0;
		end else begin
			done0_q <= grant0;
			done1_q <= grant1;
		end
	end

	// Remember where the read data will come from
	always_ff @(posedge clkrst_core_clk) begin
		if (!rst_n) begin
			mmio_sel_q <= 1'b0;
		end else if (mem_en) begin
			mmio_sel_q <= mem_mmio_sel;
		end
	end

	// RAM and MMIO both register their read data, pick by region
	assign rsp_rdata = mmio_sel_q ? mmio_rdata : ram_rdata;

	// Both ports see the same data bus, only done differs
	assign port0_rsp.done  = done0_q;
	assign port0_rsp.rdata = rsp_rdata;
	assign port1_rsp.done  = done1_q;
	assign port1_rsp.rdata = rsp_rdata;

endmodule

// ==== hdl/mem_sys_pkg.sv ====
package mem_sys_pkg;

	// Memory map
	localparam int RAM_ADDR_BITS    = 14;	// 16k words, 64 KB
	localparam int RAM_WORDS        = 1 << RAM_ADDR_BITS;
	localparam int FETCH_INDEX_BITS = 12;	// 4k packets of 16 bytes
	localparam int FETCH_WORDS      = 4;	// Words per fetch packet
	localparam int MMIO_SEL_BIT     = 29;	// Word address bit that selects MMIO
	localparam int MMIO_OUT_OFFSET  = 0;
	localparam int MMIO_IN_OFFSET   = 1;

	localparam string BOOTROM_FILE = "bootrom.hex";

	// Plain widths
	typedef logic [31:0]  word_t;
	typedef logic [29:0]  word_addr_t;	// Bit 29 set for MMIO
	typedef logic [3:0]   byte_en_t;	// All zero means read
	typedef logic [RAM_ADDR_BITS-1:0] ram_index_t;
	typedef logic [27:0]  fetch_addr_t;	// 16-byte units
	typedef logic [127:0] fetch_packet_t;	// Lowest word in bits 31:0

	// One data port request, held by the core until done
	typedef struct packed {
		word_addr_t addr;
		byte_en_t   write;
		word_t      wdata;
	} data_req_t;

	// Response back to the core
	typedef struct packed {
		logic  done;	// One-cycle strobe
		word_t rdata;	// Valid with done on reads only
	} data_rsp_t;

	// Offset field below the MMIO select bit
	typedef logic [MMIO_SEL_BIT-1:0] mmio_offset_t;

endpackage
